// ==== files.f ====
+incdir+.
zet_bus_pkg.sv
wb_if.sv
rst_debounce.sv
wb_switch.sv
irq_ctrl.sv
gpio_leds.sv
kotku_fabric.sv
tb_kotku.sv

// ==== gpio_leds.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_leds (
  input  logic       clk,
  input  logic       rst_i,
  wb_if.slave        bus,
  input  logic [7:0] sw_i,
  output logic [7:0] leds_o
);

  zet_bus_pkg::bus_dat_t dat_q;
  logic [7:0]            leds_q;
  logic                  req;
  logic                  ack_q;
  logic                  take;

  assign req  = bus.cyc & bus.stb;
  assign take = req & ~ack_q;  // One access per strobe

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      leds_q <= '0;
    end else begin
      ack_q <= take;
      if (take && bus.we && bus.sel[0])
        leds_q <= bus.dat_w[7:0];  // Low byte lane only
    end
    if (take)
      dat_q <= {sw_i, leds_q};  // Switches high, LEDs low
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = dat_q;
  assign leds_o    = leds_q;

endmodule

`default_nettype wire

// ==== irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
  input  logic                               clk,
  input  logic                               rst_i,
  input  logic [zet_bus_pkg::NUM_IRQ-1:0]    intv_i,
  input  logic                               inta_i,
  input  logic                               nmia_i,
  input  zet_bus_pkg::bus_dat_t              sw_dat_i,
  output logic                               intr_o,
  output zet_bus_pkg::bus_dat_t              m_dat_o
);

  localparam int N    = zet_bus_pkg::NUM_IRQ;
  localparam int ID_W = zet_bus_pkg::IRQ_ID_W;

  logic [N-1:0]    intv_q;
  logic [N-1:0]    pend_q;
  logic [N-1:0]    rise;
  logic [N-1:0]    clr;
  logic [ID_W-1:0] low_id;
  logic [ID_W-1:0] iid_q;
  logic [ID_W-1:0] srv_id;
  logic            inta_q;
  logic            ack_edge;

  assign rise     = intv_i & ~intv_q;
  assign ack_edge = inta_i & ~inta_q;  // One line served per pulse

  //////////////////////////////////////////////////
  // Lowest pending line wins

  always_comb begin
    low_id = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (pend_q[i])
        low_id = ID_W'(i);
    end
  end

  always_comb begin
    clr = '0;
    if (ack_edge)
      clr[low_id] = 1'b1;
  end

  always_ff @(posedge clk) begin
    intv_q <= intv_i;  // Line levels one clock back
    if (rst_i) begin
      pend_q <= '0;
      inta_q <= 1'b0;
    end else begin
      pend_q <= (pend_q & ~clr) | rise;  // A new edge beats the clear
      inta_q <= inta_i;
    end
    if (ack_edge)
      iid_q <= low_id;
  end

  // Hold the served id for a long acknowledge
  assign srv_id = inta_q ? iid_q : low_id;
  assign intr_o = |pend_q;

  //////////////////////////////////////////////////
  // CPU read data

  always_comb begin
    if (nmia_i)
      m_dat_o = zet_bus_pkg::NMI_VECTOR;
    else if (inta_i)
      m_dat_o = zet_bus_pkg::IRQ_VECTOR_BASE | zet_bus_pkg::bus_dat_t'(srv_id);
    else
      m_dat_o = sw_dat_i;  // Plain bus read
  end

endmodule

`default_nettype wire

// ==== kotku_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module kotku_fabric #(
  parameter int unsigned RST_HOLD = 131071
) (
  input  logic                  clk,
  input  logic                  rst_lck,

  // CPU master port
  input  zet_bus_pkg::bus_adr_t m_adr_i,
  input  zet_bus_pkg::bus_dat_t m_dat_i,
  input  zet_bus_pkg::bus_sel_t m_sel_i,
  input  logic                  m_we_i,
  input  logic                  m_cyc_i,
  input  logic                  m_stb_i,
  output zet_bus_pkg::bus_dat_t m_dat_o,
  output logic                  m_ack_o,

  // Interrupts
  input  logic                  inta_i,
  input  logic                  nmia_i,
  output logic                  intr_o,
  input  logic [zet_bus_pkg::NUM_IRQ-1:0] intv_i,

  // Base memory
  output zet_bus_pkg::bus_adr_t mem_adr_o,
  output zet_bus_pkg::bus_dat_t mem_dat_o,
  output zet_bus_pkg::bus_sel_t mem_sel_o,
  output logic                  mem_we_o,
  output logic                  mem_cyc_o,
  output logic                  mem_stb_o,
  input  zet_bus_pkg::bus_dat_t mem_dat_i,
  input  logic                  mem_ack_i,

  // Expansion I/O
  output zet_bus_pkg::bus_adr_t iox_adr_o,
  output zet_bus_pkg::bus_dat_t iox_dat_o,
  output zet_bus_pkg::bus_sel_t iox_sel_o,
  output logic                  iox_we_o,
  output logic                  iox_cyc_o,
  output logic                  iox_stb_o,
  input  zet_bus_pkg::bus_dat_t iox_dat_i,
  input  logic                  iox_ack_i,

  // Board I/O
  input  logic [7:0]            sw_i,
  output logic [7:0]            leds_o,
  output logic                  sys_rst_o
);

  zet_bus_pkg::bus_dat_t sw_dat;
  logic                  sys_rst;

  wb_if mem_ch ();
  wb_if iox_ch ();
  wb_if led_ch ();

  //////////////////////////////////////////////////
  // Blocks

  rst_debounce #(
    .RST_HOLD (RST_HOLD)
  ) i_rst_debounce (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst)
  );

  wb_switch i_wb_switch (
    .clk      (clk),
    .m_adr_i  (m_adr_i),
    .m_dat_i  (m_dat_i),
    .m_sel_i  (m_sel_i),
    .m_we_i   (m_we_i),
    .m_cyc_i  (m_cyc_i),
    .m_stb_i  (m_stb_i),
    .sw_dat_o (sw_dat),
    .m_ack_o  (m_ack_o),
    .mem_ch   (mem_ch),
    .iox_ch   (iox_ch),
    .led_ch   (led_ch)
  );

  irq_ctrl i_irq_ctrl (
    .clk      (clk),
    .rst_i    (sys_rst),
    .intv_i   (intv_i),
    .inta_i   (inta_i),
    .nmia_i   (nmia_i),
    .sw_dat_i (sw_dat),   // Overridden during acknowledge
    .intr_o   (intr_o),
    .m_dat_o  (m_dat_o)
  );

  gpio_leds i_gpio_leds (
    .clk    (clk),
    .rst_i  (sys_rst),
    .bus    (led_ch),
    .sw_i   (sw_i),
    .leds_o (leds_o)
  );

  //////////////////////////////////////////////////
  // External slave pins

  assign mem_adr_o    = mem_ch.adr;
  assign mem_dat_o    = mem_ch.dat_w;
  assign mem_sel_o    = mem_ch.sel;
  assign mem_we_o     = mem_ch.we;
  assign mem_cyc_o    = mem_ch.cyc;
  assign mem_stb_o    = mem_ch.stb;
  assign mem_ch.dat_r = mem_dat_i;
  assign mem_ch.ack   = mem_ack_i;

  assign iox_adr_o    = iox_ch.adr;
  assign iox_dat_o    = iox_ch.dat_w;
  assign iox_sel_o    = iox_ch.sel;
  assign iox_we_o     = iox_ch.we;
  assign iox_cyc_o    = iox_ch.cyc;
  assign iox_stb_o    = iox_ch.stb;
  assign iox_ch.dat_r = iox_dat_i;
  assign iox_ch.ack   = iox_ack_i;

  assign sys_rst_o = sys_rst;

endmodule

`default_nettype wire

// ==== rst_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

module rst_debounce #(
  parameter int unsigned RST_HOLD = 131071
) (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_o
);

  localparam int CNT_W = $clog2(RST_HOLD + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_nxt;
  logic             sys_rst_q;

  // Count down to zero and stay there
  assign cnt_nxt = (cnt_q != '0) ? cnt_q - CNT_W'(1) : cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q     <= CNT_W'(RST_HOLD);  // Reload while the lock is low
      sys_rst_q <= 1'b1;
    end else begin
      cnt_q     <= cnt_nxt;
      sys_rst_q <= (cnt_nxt != '0);   // Drops on the last count
    end
  end

  assign sys_rst_o = sys_rst_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the bus core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_kotku -f files.f -o tb_kotku_sim
./obj_dir/tb_kotku_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb_kotku_model.svh ====
`ifndef TB_KOTKU_MODEL_SVH
`define TB_KOTKU_MODEL_SVH

// Reference model of the bus core
// I/O addresses driven by the testbench keep bits 18:15 at zero

logic [7:0] led_reg;   // LED register as the CPU last wrote it
logic [7:0] irq_pend;  // Lines seen rising and not yet served

// Priority decode in the order LED, expansion I/O, memory
function automatic zet_bus_pkg::slave_e decode_target(input zet_bus_pkg::bus_adr_t adr);
  logic [15:0]         port;
  zet_bus_pkg::slave_e tgt;
  port = {adr[14:0], 1'b0};  // Byte port of an I/O word
  if (!adr[19])
    tgt = zet_bus_pkg::SLV_MEM;
  else if (port >= 16'hf100 && port <= 16'hf103)
    tgt = zet_bus_pkg::SLV_LED;
  else if (port >= 16'h03f8 && port <= 16'h03ff)
    tgt = zet_bus_pkg::SLV_IO;
  else
    tgt = zet_bus_pkg::SLV_DEF;
  return tgt;
endfunction

function automatic logic [2:0] lowest_pending(input logic [7:0] pend);
  logic [2:0] id;
  logic       found;
  id    = '0;
  found = 1'b0;
  for (int i = 0; i < 8; i++) begin
    if (pend[i] && !found) begin
      id    = 3'(i);
      found = 1'b1;
    end
  end
  return id;
endfunction

`endif

// ==== tb_kotku.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kotku;

  `include "tb_kotku_model.svh"

  localparam int RST_HOLD = 16;
  localparam int RST_WAIT = 64;  // Limit for the reset release
  localparam int BUS_WAIT = 16;  // Limit for one bus cycle

  logic                          clk;
  logic                          rst_lck;
  zet_bus_pkg::bus_adr_t         m_adr_i;
  zet_bus_pkg::bus_dat_t         m_dat_i;
  zet_bus_pkg::bus_sel_t         m_sel_i;
  logic                          m_we_i;
  logic                          m_cyc_i;
  logic                          m_stb_i;
  zet_bus_pkg::bus_dat_t         m_dat_o;
  logic                          m_ack_o;
  logic                          inta_i;
  logic                          nmia_i;
  logic                          intr_o;
  logic [zet_bus_pkg::NUM_IRQ-1:0] intv_i;
  zet_bus_pkg::bus_adr_t         mem_adr_o;
  zet_bus_pkg::bus_dat_t         mem_dat_o;
  zet_bus_pkg::bus_sel_t         mem_sel_o;
  logic                          mem_we_o;
  logic                          mem_cyc_o;
  logic                          mem_stb_o;
  zet_bus_pkg::bus_dat_t         mem_dat_i;
  logic                          mem_ack_i;
  zet_bus_pkg::bus_adr_t         iox_adr_o;
  zet_bus_pkg::bus_dat_t         iox_dat_o;
  zet_bus_pkg::bus_sel_t         iox_sel_o;
  logic                          iox_we_o;
  logic                          iox_cyc_o;
  logic                          iox_stb_o;
  zet_bus_pkg::bus_dat_t         iox_dat_i;
  logic                          iox_ack_i;
  logic [7:0]                    sw_i;
  logic [7:0]                    leds_o;
  logic                          sys_rst_o;

  logic        mem_rdy;  // Wait states of the external slaves are over
  logic        iox_rdy;
  int          err_cnt;
  int          chk_cnt;

  kotku_fabric #(
    .RST_HOLD (RST_HOLD)
  ) i_dut (.*);

  //////////////////////////////////////////////////
  // Behavioral external slaves

  function automatic zet_bus_pkg::bus_dat_t mem_word(input zet_bus_pkg::bus_adr_t adr);
    return adr[15:0] ^ {adr[19:16], 12'ha53};
  endfunction

  function automatic zet_bus_pkg::bus_dat_t iox_word(input zet_bus_pkg::bus_adr_t adr);
    return {adr[7:0], ~adr[7:0]} ^ 16'h3c0f;
  endfunction

  assign mem_dat_i = mem_word(mem_adr_o);
  assign mem_ack_i = mem_cyc_o & mem_stb_o & mem_rdy;
  assign iox_dat_i = iox_word(iox_adr_o);
  assign iox_ack_i = iox_cyc_o & iox_stb_o & iox_rdy;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Compare tasks

  task automatic check_dat(input string name, input zet_bus_pkg::bus_dat_t got,
                           input zet_bus_pkg::bus_dat_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_adr(input string name, input zet_bus_pkg::bus_adr_t got,
                           input zet_bus_pkg::bus_adr_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input zet_bus_pkg::bus_sel_t got,
                           input zet_bus_pkg::bus_sel_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_slave(input string name, input zet_bus_pkg::slave_e got,
                             input zet_bus_pkg::slave_e exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got 0x%h (%s), expected 0x%h (%s)",
               name, got, got.name(), exp, exp.name());
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
      $display("%-8s done, no errors", name);
    else
      $display("%-8s done, %0d errors", name, err_cnt - errs_before);
  endtask

  //////////////////////////////////////////////////
  // Bus master

  function automatic zet_bus_pkg::bus_adr_t random_adr();
    zet_bus_pkg::bus_adr_t adr;
    case (2'($urandom))
      2'd0:    adr = {1'b0, 19'($urandom)};                   // Memory
      2'd1:    adr = {1'b1, 4'h0, 15'h01fc + 15'($urandom % 4)};
      2'd2:    adr = {1'b1, 4'h0, 15'h7880 + 15'($urandom % 2)};
      default: adr = {1'b1, 4'h0, 15'($urandom)};             // Any I/O port
    endcase
    return adr;
  endfunction

  // Which channel carries the first cycle of a request
  task automatic check_route(input zet_bus_pkg::bus_adr_t adr, input logic we,
                             input zet_bus_pkg::bus_dat_t wdat,
                             input zet_bus_pkg::bus_sel_t sel,
                             input zet_bus_pkg::slave_e exp_tgt);
    zet_bus_pkg::slave_e got;
    int                  n_sel;
    n_sel = int'(mem_cyc_o) + int'(iox_cyc_o) + int'(i_dut.led_ch.cyc);
    if (n_sel > 1) begin
      err_cnt++;
      $display("Error: more than one slave channel selected for address 0x%h", adr);
    end
    if (mem_cyc_o)
      got = zet_bus_pkg::SLV_MEM;
    else if (iox_cyc_o)
      got = zet_bus_pkg::SLV_IO;
    else if (i_dut.led_ch.cyc)
      got = zet_bus_pkg::SLV_LED;
    else
      got = zet_bus_pkg::SLV_DEF;
    check_slave("slave select", got, exp_tgt);
    check_bit("mem_stb_o", mem_stb_o, exp_tgt == zet_bus_pkg::SLV_MEM);
    check_bit("iox_stb_o", iox_stb_o, exp_tgt == zet_bus_pkg::SLV_IO);
    if (got == zet_bus_pkg::SLV_MEM) begin
      check_adr("mem_adr_o", mem_adr_o, adr);
      check_dat("mem_dat_o", mem_dat_o, wdat);
      check_sel("mem_sel_o", mem_sel_o, sel);
      check_bit("mem_we_o", mem_we_o, we);
    end
    if (got == zet_bus_pkg::SLV_IO) begin
      check_adr("iox_adr_o", iox_adr_o, adr);
      check_dat("iox_dat_o", iox_dat_o, wdat);
      check_sel("iox_sel_o", iox_sel_o, sel);
      check_bit("iox_we_o", iox_we_o, we);
    end
  endtask

  task automatic bus_cycle(input zet_bus_pkg::bus_adr_t adr, input logic we,
                           input zet_bus_pkg::bus_dat_t wdat,
                           input zet_bus_pkg::bus_sel_t sel);
    zet_bus_pkg::slave_e   exp_tgt;
    zet_bus_pkg::bus_dat_t exp_rd;
    int                    d_mem;
    int                    d_iox;
    int                    exp_lat;
    int                    k;
    logic                  acked;
    d_mem   = int'($urandom % 4);
    d_iox   = int'($urandom % 4);
    exp_tgt = decode_target(adr);
    case (exp_tgt)
      zet_bus_pkg::SLV_MEM: begin
        exp_lat = d_mem;
        exp_rd  = mem_word(adr);
      end
      zet_bus_pkg::SLV_IO: begin
        exp_lat = d_iox;
        exp_rd  = iox_word(adr);
      end
      zet_bus_pkg::SLV_LED: begin
        exp_lat = 1;                 // Registered ack
        exp_rd  = {sw_i, led_reg};
      end
      default: begin
        exp_lat = 0;
        exp_rd  = '0;
      end
    endcase
    @(negedge clk);
    m_adr_i = adr;
    m_dat_i = wdat;
    m_sel_i = sel;
    m_we_i  = we;
    m_cyc_i = 1'b1;
    m_stb_i = 1'b1;
    k       = 0;
    acked   = 1'b0;
    while (!acked && k <= BUS_WAIT) begin
      mem_rdy = (k >= d_mem);
      iox_rdy = (k >= d_iox);
      #1;
      if (k == 0)
        check_route(adr, we, wdat, sel, exp_tgt);
      check_bit("m_ack_o", m_ack_o, k == exp_lat);
      if (m_ack_o) begin
        acked = 1'b1;
        if (!we)
          check_dat("m_dat_o", m_dat_o, exp_rd);
      end else begin
        k++;
        @(negedge clk);
      end
    end
    if (!acked) begin
      err_cnt++;
      $display("Error: no m_ack_o within %0d cycles for address 0x%h", BUS_WAIT, adr);
    end
    @(negedge clk);
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    mem_rdy = 1'b0;
    iox_rdy = 1'b0;
    if (exp_tgt == zet_bus_pkg::SLV_LED && we && sel[0])
      led_reg = wdat[7:0];
    #1;
    check_dat("leds_o", {8'h00, leds_o}, {8'h00, led_reg});
  endtask

  //////////////////////////////////////////////////
  // Interrupt side

  task automatic raise_irq(input logic [7:0] pat);
    @(negedge clk);
    intv_i   = pat;
    irq_pend = irq_pend | pat;
    @(negedge clk);
    intv_i = '0;  // Falling edges leave pending bits alone
    #1;
    check_bit("intr_o", intr_o, 1'b1);
  endtask

  task automatic serve_irq(input logic with_nmi);
    logic [2:0]            id;
    zet_bus_pkg::bus_dat_t exp_vec;
    int                    len;
    id      = lowest_pending(irq_pend);
    exp_vec = with_nmi ? 16'h0002 : 16'h0008 + {13'h0, id};
    len     = 1 + int'($urandom % 2);  // Acknowledge held one or two cycles
    irq_pend[id] = 1'b0;
    for (int c = 0; c < len; c++) begin
      @(negedge clk);
      inta_i = 1'b1;
      nmia_i = with_nmi;
      #1;
      check_dat("m_dat_o", m_dat_o, exp_vec);
    end
    @(negedge clk);
    inta_i = 1'b0;
    nmia_i = 1'b0;
    #1;
    check_bit("intr_o", intr_o, irq_pend != 8'h00);
  endtask

  task automatic drain_irq();
    int n;
    n = 0;
    while (irq_pend != 8'h00 && n <= 8) begin
      serve_irq(1'b0);
      n++;
    end
    if (irq_pend != 8'h00) begin
      err_cnt++;
      $display("Error: interrupts still pending after %0d acknowledges", n);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    int                    k;
    int                    n;
    int                    start;
    logic                  done;
    zet_bus_pkg::bus_adr_t adr;
    rst_lck  = 1'b0;
    m_adr_i  = '0;
    m_dat_i  = '0;
    m_sel_i  = '0;
    m_we_i   = 1'b0;
    m_cyc_i  = 1'b0;
    m_stb_i  = 1'b0;
    inta_i   = 1'b0;
    nmia_i   = 1'b0;
    intv_i   = '0;
    sw_i     = '0;
    mem_rdy  = 1'b0;
    iox_rdy  = 1'b0;
    err_cnt  = 0;
    chk_cnt  = 0;
    led_reg  = '0;
    irq_pend = '0;
    void'($urandom(32'h8f02_c8d0));

    // Reset release and hold time
    start = err_cnt;
    repeat (10) @(negedge clk);
    rst_lck = 1'b1;
    #1;
    k    = 0;
    done = 1'b0;
    while (!done) begin
      check_bit("sys_rst_o", sys_rst_o, k < RST_HOLD);
      if (!sys_rst_o) begin
        done = 1'b1;
      end else if (k == RST_WAIT) begin
        err_cnt++;
        $display("Error: sys_rst_o still high %0d cycles after reset release", k);
        done = 1'b1;
      end else begin
        k++;
        @(negedge clk);
        #1;
      end
    end
    check_dat("leds_o", {8'h00, leds_o}, 16'h0000);
    check_bit("intr_o", intr_o, 1'b0);
    check_bit("m_ack_o", m_ack_o, 1'b0);
    end_test("reset", start);

    start = err_cnt;
    for (int i = 0; i < 48; i++) begin
      adr = random_adr();
      bus_cycle(adr, 1'($urandom), 16'($urandom), 2'($urandom));
    end
    end_test("decode", start);

    // Ports 0x1000 - 0x17fe hit no window
    start = err_cnt;
    for (int i = 0; i < 8; i++) begin
      adr = {1'b1, 4'h0, 15'h0800 + 15'($urandom % 32'h400)};
      bus_cycle(adr, 1'($urandom), 16'($urandom), 2'b11);
    end
    end_test("default", start);

    start = err_cnt;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      sw_i = 8'($urandom);
      bus_cycle({1'b1, 4'h0, 15'h7880}, 1'b1, 16'($urandom), 2'($urandom));
      bus_cycle({1'b1, 4'h0, 15'h7881}, 1'b0, 16'h0000, 2'b11);
    end
    end_test("leds", start);

    start = err_cnt;
    for (int r = 0; r < 6; r++) begin
      raise_irq(8'($urandom) | (8'h01 << ($urandom % 8)));
      n = int'($urandom % 3);
      for (int j = 0; j < n; j++) begin
        if (irq_pend != 8'h00)
          serve_irq(1'b0);
      end
    end
    drain_irq();
    end_test("irq", start);

    // NMI alone, then together with an interrupt acknowledge
    start = err_cnt;
    @(negedge clk);
    nmia_i = 1'b1;
    #1;
    check_dat("m_dat_o", m_dat_o, 16'h0002);
    raise_irq(8'($urandom) | 8'h80);
    serve_irq(1'b1);
    drain_irq();
    end_test("nmi", start);

    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One Wishbone classic slave channel out of the address switch
interface wb_if;

  zet_bus_pkg::bus_adr_t adr;
  zet_bus_pkg::bus_dat_t dat_w;
  zet_bus_pkg::bus_dat_t dat_r;
  zet_bus_pkg::bus_sel_t sel;
  logic                  we;
  logic                  cyc;
  logic                  stb;
  logic                  ack;

  // Switch side
  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack
  );

  // Slave side
  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// ==== wb_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_switch (
  input  logic                  clk,

  // CPU side
  input  zet_bus_pkg::bus_adr_t m_adr_i,
  input  zet_bus_pkg::bus_dat_t m_dat_i,
  input  zet_bus_pkg::bus_sel_t m_sel_i,
  input  logic                  m_we_i,
  input  logic                  m_cyc_i,
  input  logic                  m_stb_i,
  output zet_bus_pkg::bus_dat_t sw_dat_o,
  output logic                  m_ack_o,

  // Slave channels
  wb_if.master                  mem_ch,
  wb_if.master                  iox_ch,
  wb_if.master                  led_ch
);

  zet_bus_pkg::slave_e   hit;      // Fresh decode of m_adr_i
  zet_bus_pkg::slave_e   sel_q;    // Target held for a long cycle
  zet_bus_pkg::slave_e   route;
  zet_bus_pkg::bus_dat_t dat_mux;
  logic                  ack_mux;
  logic                  req;
  logic                  busy_q;
  logic                  def_ack;

  function automatic logic win_hit(zet_bus_pkg::bus_adr_t adr,
                                   zet_bus_pkg::bus_adr_t base,
                                   zet_bus_pkg::bus_adr_t mask);
    return (adr & mask) == base;
  endfunction

  assign req = m_cyc_i & m_stb_i;

  //////////////////////////////////////////////////
  // Address decode, highest priority first

  always_comb begin
    if (win_hit(m_adr_i, zet_bus_pkg::LED_ADDR, zet_bus_pkg::LED_MASK))
      hit = zet_bus_pkg::SLV_LED;
    else if (win_hit(m_adr_i, zet_bus_pkg::IOX_ADDR, zet_bus_pkg::IOX_MASK))
      hit = zet_bus_pkg::SLV_IO;
    else if (win_hit(m_adr_i, zet_bus_pkg::MEM_ADDR, zet_bus_pkg::MEM_MASK))
      hit = zet_bus_pkg::SLV_MEM;
    else
      hit = zet_bus_pkg::SLV_DEF;
  end

  // First cycle routes from the decode, later cycles keep that target
  always_ff @(posedge clk) begin
    busy_q <= req & ~m_ack_o;  // High while the cycle waits for ack
    if (req && !busy_q)
      sel_q <= hit;
  end

  assign route = busy_q ? sel_q : hit;

  //////////////////////////////////////////////////
  // Request fan-out

  assign mem_ch.adr   = m_adr_i;
  assign mem_ch.dat_w = m_dat_i;
  assign mem_ch.sel   = m_sel_i;
  assign mem_ch.we    = m_we_i;
  assign mem_ch.cyc   = m_cyc_i & (route == zet_bus_pkg::SLV_MEM);
  assign mem_ch.stb   = m_stb_i & (route == zet_bus_pkg::SLV_MEM);

  assign iox_ch.adr   = m_adr_i;
  assign iox_ch.dat_w = m_dat_i;
  assign iox_ch.sel   = m_sel_i;
  assign iox_ch.we    = m_we_i;
  assign iox_ch.cyc   = m_cyc_i & (route == zet_bus_pkg::SLV_IO);
  assign iox_ch.stb   = m_stb_i & (route == zet_bus_pkg::SLV_IO);

  assign led_ch.adr   = m_adr_i;
  assign led_ch.dat_w = m_dat_i;
  assign led_ch.sel   = m_sel_i;
  assign led_ch.we    = m_we_i;
  assign led_ch.cyc   = m_cyc_i & (route == zet_bus_pkg::SLV_LED);
  assign led_ch.stb   = m_stb_i & (route == zet_bus_pkg::SLV_LED);

  // Default slave ends unmapped cycles at once
  assign def_ack = req & (route == zet_bus_pkg::SLV_DEF);

  //////////////////////////////////////////////////
  // Return path

  always_comb begin
    unique case (route)
      zet_bus_pkg::SLV_MEM: begin
        dat_mux = mem_ch.dat_r;
        ack_mux = mem_ch.ack;
      end
      zet_bus_pkg::SLV_IO: begin
        dat_mux = iox_ch.dat_r;
        ack_mux = iox_ch.ack;
      end
      zet_bus_pkg::SLV_LED: begin
        dat_mux = led_ch.dat_r;
        ack_mux = led_ch.ack;
      end
      default: begin
        dat_mux = '0;  // Reads as zero
        ack_mux = def_ack;
      end
    endcase
  end

  assign sw_dat_o = dat_mux;
  assign m_ack_o  = req & ack_mux;

endmodule

`default_nettype wire

// ==== zet_bus_pkg.sv ====
`default_nettype none

package zet_bus_pkg;

  //////////////////////////////////////////////////
  // Bus word types

  typedef logic [19:0] bus_adr_t;  // Bit 19 is the I/O tag
  typedef logic [15:0] bus_dat_t;
  typedef logic [1:0]  bus_sel_t;

  // Route targets of the address switch
  typedef enum logic [1:0] {
    SLV_MEM,
    SLV_IO,
    SLV_LED,
    SLV_DEF
  } slave_e;

  //////////////////////////////////////////////////
  // Decode windows in tagged word addresses

  // Memory 0x00000 - 0xfffff
  localparam bus_adr_t MEM_ADDR = 20'b0_0000_0000_0000_0000_000;
  localparam bus_adr_t MEM_MASK = 20'b1_0000_0000_0000_0000_000;

  // Expansion I/O 0x3f8 - 0x3ff
  localparam bus_adr_t IOX_ADDR = 20'b1_0000_0000_0011_1111_100;
  localparam bus_adr_t IOX_MASK = 20'b1_0000_1111_1111_1111_100;

  // LED port 0xf100 - 0xf103
  localparam bus_adr_t LED_ADDR = 20'b1_0000_1111_0001_0000_000;
  localparam bus_adr_t LED_MASK = 20'b1_0000_1111_1111_1111_110;

  //////////////////////////////////////////////////
  // Interrupt acknowledge data

  localparam bus_dat_t NMI_VECTOR      = 16'h0002;
  localparam bus_dat_t IRQ_VECTOR_BASE = 16'h0008;  // Low bits carry the line id

  localparam int NUM_IRQ  = 8;
  localparam int IRQ_ID_W = $clog2(NUM_IRQ);

endpackage

`default_nettype wire
